// ==== hdl/geom_cfg.svh ====
`ifndef GEOM_CFG_SVH
`define GEOM_CFG_SVH

// Width of one signed fixed-point value
`define GEOM_DATAWIDTH 18

// Fraction bits, so 1.0 is 1 << 12
`define GEOM_FRACBITS 12

// Clip-space vertices buffered between shader and assembler, power of two
`define GEOM_FIFO_DEPTH 16

`endif

// ==== hdl/geom_pkg.sv ====
`include "geom_cfg.svh"

package geom_pkg;

    // Signed Q-format scalar
    typedef logic signed [`GEOM_DATAWIDTH-1:0] fixed_t;

    // Full-width product of two scalars
    typedef logic signed [2*`GEOM_DATAWIDTH-1:0] prod_t;

    // Object-space vertex
    typedef struct packed {
        fixed_t x;
        fixed_t y;
        fixed_t z;
    } vec3_t;

    // Clip-space vertex, also one matrix row
    typedef struct packed {
        fixed_t x;
        fixed_t y;
        fixed_t z;
        fixed_t w;
    } vec4_t;

    typedef struct packed {
        vec4_t r0;
        vec4_t r1;
        vec4_t r2;
        vec4_t r3;
    } mat4_t;

    typedef struct packed {
        vec4_t v0;
        vec4_t v1;
        vec4_t v2;
        logic  reject;
    } tri_t;

    typedef enum logic [1:0] {
        SHADER_IDLE,
        SHADER_COMPUTING,
        SHADER_FINISHED
    } shader_state_t;

endpackage

// ==== hdl/mat_vec_mul.sv ====
`timescale 1ns/1ns

`include "geom_cfg.svh"

module mat_vec_mul (
    input  logic            clk,
    input  logic            rstn,
    input  geom_pkg::mat4_t i_mat,
    input  geom_pkg::vec4_t i_vec,
    input  logic            i_dv,
    output geom_pkg::vec4_t o_vec,
    output logic            o_dv
);
    import geom_pkg::*;

    // Element views, index 3 is row r0 and component x, index 0 is row r3 and w
    fixed_t [3:0][3:0] mat_e;
    fixed_t [3:0]      vec_e;

    // Pipeline registers
    prod_t  [3:0][3:0] prod_q;
    fixed_t [3:0][3:0] shift_q;
    fixed_t [3:0][1:0] pair_q;
    fixed_t [3:0]      sum_q;

    // Strobe travels alongside the data stages
    logic   [3:0]      dv_sr;

    assign mat_e = i_mat;
    assign vec_e = i_vec;

    always_ff @(posedge clk) begin
        for (int r = 0; r < 4; r++) begin
            // Stage 1, full-width products
            for (int c = 0; c < 4; c++) begin
                prod_q[r][c] <= mat_e[r][c] * vec_e[c];
            end

            // Stage 2, drop the extra fraction bits
            for (int c = 0; c < 4; c++) begin
                shift_q[r][c] <= fixed_t'(prod_q[r][c] >>> `GEOM_FRACBITS);
            end

            // Stage 3, pairwise sums
            pair_q[r][1] <= shift_q[r][3] + shift_q[r][2];
            pair_q[r][0] <= shift_q[r][1] + shift_q[r][0];

            // Stage 4, dot product of row r
            sum_q[r] <= pair_q[r][1] + pair_q[r][0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            dv_sr <= '0;
        end else begin
            dv_sr <= {dv_sr[2:0], i_dv};
        end
    end

    assign o_vec = sum_q;
    assign o_dv  = dv_sr[3];

endmodule

// ==== hdl/vertex_shader.sv ====
`timescale 1ns/1ns

`include "geom_cfg.svh"

module vertex_shader (
    input  logic            clk,
    input  logic            rstn,

    // Matrix load
    input  geom_pkg::mat4_t i_mvp,
    input  logic            i_mvp_dv,

    // Object-space vertex stream
    input  geom_pkg::vec3_t i_vertex,
    input  logic            i_vertex_dv,
    input  logic            i_vertex_last,

    // Status
    output logic            o_ready,
    output logic            o_finished,

    // Clip-space vertex stream
    output geom_pkg::vec4_t o_vertex,
    output logic            o_vertex_dv
);
    import geom_pkg::*;

    localparam fixed_t FIXED_ONE = fixed_t'(1 << `GEOM_FRACBITS);

    shader_state_t state;
    shader_state_t next_state;

    // Matrix for the current draw
    mat4_t r_mvp;
    logic  r_mvp_valid;

    // Homogeneous vertex into the multiplier
    vec4_t r_vec;
    logic  r_vec_dv;

    // Last marker delayed by input register plus multiplier depth
    logic [4:0] last_sr;

    mat_vec_mul u_mat_vec_mul (
        .clk   (clk),
        .rstn  (rstn),
        .i_mat (r_mvp),
        .i_vec (r_vec),
        .i_dv  (r_vec_dv),
        .o_vec (o_vertex),
        .o_dv  (o_vertex_dv)
    );

    // Matrix storage, wiped at the end of every draw
    always_ff @(posedge clk) begin
        if (state == SHADER_FINISHED) begin
            r_mvp <= '0;
        end else if (i_mvp_dv) begin
            r_mvp <= i_mvp;
        end
    end

    always_ff @(posedge clk) begin
        r_vec.x <= i_vertex.x;
        r_vec.y <= i_vertex.y;
        r_vec.z <= i_vertex.z;
        r_vec.w <= FIXED_ONE;
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state       <= SHADER_IDLE;
            r_mvp_valid <= 1'b0;
            r_vec_dv    <= 1'b0;
            last_sr     <= '0;
        end else begin
            state    <= next_state;
            r_vec_dv <= i_vertex_dv;
            last_sr  <= {last_sr[3:0], i_vertex_last};

            if (state == SHADER_FINISHED) begin
                r_mvp_valid <= 1'b0;
            end else if (i_mvp_dv) begin
                r_mvp_valid <= 1'b1;
            end
        end
    end

    always_comb begin
        next_state = state;
        o_ready    = 1'b0;
        o_finished = 1'b0;

        case (state)
            SHADER_IDLE: begin
                if (r_mvp_valid) begin
                    next_state = SHADER_COMPUTING;
                end
            end

            SHADER_COMPUTING: begin
                o_ready = 1'b1;
                // Last vertex has left the multiplier
                if (last_sr[4]) begin
                    next_state = SHADER_FINISHED;
                end
            end

            SHADER_FINISHED: begin
                o_finished = 1'b1;
                next_state = SHADER_IDLE;
            end

            default: begin
                next_state = SHADER_IDLE;
            end
        endcase
    end

endmodule

// ==== hdl/vertex_fifo.sv ====
`timescale 1ns/1ns

`include "geom_cfg.svh"

module vertex_fifo (
    input  logic            clk,
    input  logic            rstn,
    input  logic            i_wr,
    input  geom_pkg::vec4_t i_wr_data,
    input  logic            i_rd,
    output geom_pkg::vec4_t o_rd_data,
    output logic            o_not_empty,
    output logic            o_overflow
);
    import geom_pkg::*;

    localparam int DEPTH = `GEOM_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    vec4_t            mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             full;
    logic             do_wr;
    logic             do_rd;

    assign full        = (count == (PTR_W+1)'(DEPTH));
    assign o_not_empty = (count != '0);
    assign do_wr       = i_wr && !full;
    assign do_rd       = i_rd && o_not_empty;

    // Head entry shown without a register stage
    assign o_rd_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= i_wr_data;
        end
    end

    // Pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            o_overflow <= 1'b0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end

            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase

            // Lost vertex, held until reset
            if (i_wr && full) begin
                o_overflow <= 1'b1;
            end
        end
    end

endmodule

// ==== hdl/primitive_assembler.sv ====
`timescale 1ns/1ns

module primitive_assembler (
    input  logic            clk,
    input  logic            rstn,
    input  logic            i_not_empty,
    input  geom_pkg::vec4_t i_vertex,
    output logic            o_pop,
    output geom_pkg::tri_t  o_tri,
    output logic            o_tri_dv
);
    import geom_pkg::*;

    typedef enum logic {
        ASM_COLLECT,
        ASM_TEST
    } asm_state_t;

    localparam logic [2:0] LAST_PLANE = 3'd5;

    asm_state_t state;
    logic [1:0] vtx_idx;
    logic [2:0] plane;
    logic [2:0] outside;
    tri_t       r_tri;

    // Vertex beyond one of the six clip planes
    function automatic logic is_outside(vec4_t v, logic [2:0] p);
        logic out;
        case (p)
            3'd0:    out = (v.x > v.w);
            3'd1:    out = (v.x < -v.w);
            3'd2:    out = (v.y > v.w);
            3'd3:    out = (v.y < -v.w);
            3'd4:    out = (v.z > v.w);
            3'd5:    out = (v.z < -v.w);
            default: out = 1'b0;
        endcase
        return out;
    endfunction

    assign o_pop   = (state == ASM_COLLECT) && i_not_empty;
    assign outside = {is_outside(r_tri.v2, plane),
                      is_outside(r_tri.v1, plane),
                      is_outside(r_tri.v0, plane)};
    assign o_tri   = r_tri;

    // Triangle storage doubles as the output register
    always_ff @(posedge clk) begin
        if (o_pop) begin
            case (vtx_idx)
                2'd0: r_tri.v0 <= i_vertex;
                2'd1: r_tri.v1 <= i_vertex;
                2'd2: begin
                    r_tri.v2     <= i_vertex;
                    r_tri.reject <= 1'b0;
                end
                default: r_tri.v0 <= r_tri.v0;
            endcase
        end

        // All three outside the same plane
        if (state == ASM_TEST && &outside) begin
            r_tri.reject <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state    <= ASM_COLLECT;
            vtx_idx  <= '0;
            plane    <= '0;
            o_tri_dv <= 1'b0;
        end else begin
            o_tri_dv <= 1'b0;

            case (state)
                ASM_COLLECT: begin
                    if (o_pop) begin
                        if (vtx_idx == 2'd2) begin
                            vtx_idx <= '0;
                            plane   <= '0;
                            state   <= ASM_TEST;
                        end else begin
                            vtx_idx <= vtx_idx + 1'b1;
                        end
                    end
                end

                ASM_TEST: begin
                    plane <= plane + 1'b1;
                    if (plane == LAST_PLANE) begin
                        o_tri_dv <= 1'b1;
                        state    <= ASM_COLLECT;
                    end
                end

                default: begin
                    state <= ASM_COLLECT;
                end
            endcase
        end
    end

endmodule

// ==== hdl/geom_pipeline.sv ====
`timescale 1ns/1ns

module geom_pipeline (
    input  logic            clk,
    input  logic            rstn,

    input  geom_pkg::mat4_t i_mvp,
    input  logic            i_mvp_dv,

    input  geom_pkg::vec3_t i_vertex,
    input  logic            i_vertex_dv,
    input  logic            i_vertex_last,

    output logic            o_ready,
    output logic            o_finished,
    output logic            o_overflow,

    output geom_pkg::tri_t  o_tri,
    output logic            o_tri_dv
);
    import geom_pkg::*;

    // Shader to FIFO
    vec4_t clip_vertex;
    logic  clip_vertex_dv;

    // FIFO to assembler
    vec4_t head_vertex;
    logic  head_valid;
    logic  pop;

    vertex_shader u_vertex_shader (
        .clk           (clk),
        .rstn          (rstn),
        .i_mvp         (i_mvp),
        .i_mvp_dv      (i_mvp_dv),
        .i_vertex      (i_vertex),
        .i_vertex_dv   (i_vertex_dv),
        .i_vertex_last (i_vertex_last),
        .o_ready       (o_ready),
        .o_finished    (o_finished),
        .o_vertex      (clip_vertex),
        .o_vertex_dv   (clip_vertex_dv)
    );

    vertex_fifo u_vertex_fifo (
        .clk         (clk),
        .rstn        (rstn),
        .i_wr        (clip_vertex_dv),
        .i_wr_data   (clip_vertex),
        .i_rd        (pop),
        .o_rd_data   (head_vertex),
        .o_not_empty (head_valid),
        .o_overflow  (o_overflow)
    );

    primitive_assembler u_primitive_assembler (
        .clk         (clk),
        .rstn        (rstn),
        .i_not_empty (head_valid),
        .i_vertex    (head_vertex),
        .o_pop       (pop),
        .o_tri       (o_tri),
        .o_tri_dv    (o_tri_dv)
    );

endmodule

// ==== test/geom_pipeline_tb.sv ====
`timescale 1ns/1ns

`include "geom_cfg.svh"

module geom_pipeline_tb;
    import geom_pkg::*;

    localparam int ONE = 1 << `GEOM_FRACBITS;

    // One table row is one triangle of a draw with its expected reject flag
    typedef struct packed {
        int         draw;
        vec3_t      a;
        vec3_t      b;
        vec3_t      c;
        logic       rej;
    } tri_row_t;

    logic   clk;
    logic   rstn;
    mat4_t  i_mvp;
    logic   i_mvp_dv;
    vec3_t  i_vertex;
    logic   i_vertex_dv;
    logic   i_vertex_last;
    logic   o_ready;
    logic   o_finished;
    logic   o_overflow;
    tri_t   o_tri;
    logic   o_tri_dv;

    tri_row_t tbl[$];
    vec3_t    draw_verts[$];
    logic     draw_rej[$];
    tri_t     exp_q[$];
    mat4_t    mats[3];
    int       mismatch_count;
    int       other_count;

    geom_pipeline i_dut (
        .clk           (clk),
        .rstn          (rstn),
        .i_mvp         (i_mvp),
        .i_mvp_dv      (i_mvp_dv),
        .i_vertex      (i_vertex),
        .i_vertex_dv   (i_vertex_dv),
        .i_vertex_last (i_vertex_last),
        .o_ready       (o_ready),
        .o_finished    (o_finished),
        .o_overflow    (o_overflow),
        .o_tri         (o_tri),
        .o_tri_dv      (o_tri_dv)
    );

    always #20 clk = ~clk;

    function automatic fixed_t to_fixed(real r);
        return fixed_t'($rtoi(r * ONE));
    endfunction

    function automatic vec3_t v3(real x, real y, real z);
        vec3_t v;
        v.x = to_fixed(x);
        v.y = to_fixed(y);
        v.z = to_fixed(z);
        return v;
    endfunction

    function automatic vec4_t v4(real x, real y, real z, real w);
        vec4_t v;
        v.x = to_fixed(x);
        v.y = to_fixed(y);
        v.z = to_fixed(z);
        v.w = to_fixed(w);
        return v;
    endfunction

    function automatic mat4_t diag(real sx, real sy, real sz);
        mat4_t m;
        m.r0 = v4(sx, 0.0, 0.0, 0.0);
        m.r1 = v4(0.0, sy, 0.0, 0.0);
        m.r2 = v4(0.0, 0.0, sz, 0.0);
        m.r3 = v4(0.0, 0.0, 0.0, 1.0);
        return m;
    endfunction

    // Full product shifted arithmetically by the fraction bits
    function automatic longint scaled_product(fixed_t a, fixed_t b);
        longint p;
        p = longint'(a) * longint'(b);
        return p >>> `GEOM_FRACBITS;
    endfunction

    function automatic fixed_t dot4(vec4_t r, vec4_t v);
        longint acc;
        acc = scaled_product(r.x, v.x) + scaled_product(r.y, v.y)
            + scaled_product(r.z, v.z) + scaled_product(r.w, v.w);
        return fixed_t'(acc);
    endfunction

    function automatic vec4_t to_clip(mat4_t m, vec3_t v);
        vec4_t h;
        vec4_t c;
        h.x = v.x;
        h.y = v.y;
        h.z = v.z;
        h.w = fixed_t'(ONE);
        c.x = dot4(m.r0, h);
        c.y = dot4(m.r1, h);
        c.z = dot4(m.r2, h);
        c.w = dot4(m.r3, h);
        return c;
    endfunction

    function automatic logic beyond_plane(vec4_t v, int p);
        logic out;
        case (p)
            0:       out = int'(v.x) > int'(v.w);
            1:       out = int'(v.x) < -int'(v.w);
            2:       out = int'(v.y) > int'(v.w);
            3:       out = int'(v.y) < -int'(v.w);
            4:       out = int'(v.z) > int'(v.w);
            default: out = int'(v.z) < -int'(v.w);
        endcase
        return out;
    endfunction

    function automatic logic same_plane_reject(vec4_t a, vec4_t b, vec4_t c);
        logic rej;
        rej = 1'b0;
        for (int p = 0; p < 6; p++) begin
            if (beyond_plane(a, p) && beyond_plane(b, p) && beyond_plane(c, p)) begin
                rej = 1'b1;
            end
        end
        return rej;
    endfunction

    task automatic check_bit(string name, logic exp, logic act);
        assert (act === exp) else begin
            mismatch_count++;
            $display("MISMATCH t=%0t %s expected=%0b actual=%0b", $time, name, exp, act);
        end
    endtask

    task automatic check_vec(string name, vec4_t exp, vec4_t act);
        assert (act === exp) else begin
            mismatch_count++;
            $display("MISMATCH t=%0t %s expected=%h actual=%h", $time, name, exp, act);
        end
    endtask

    task automatic add_row(int d, vec3_t a, vec3_t b, vec3_t c, logic rej);
        tri_row_t row;
        row.draw = d;
        row.a    = a;
        row.b    = b;
        row.c    = c;
        row.rej  = rej;
        tbl.push_back(row);
    endtask

    // Model triangle goes to the queue and its reject flag is held against the table
    task automatic push_expected(mat4_t m, vec3_t a, vec3_t b, vec3_t c, int idx);
        tri_t t;
        t.v0     = to_clip(m, a);
        t.v1     = to_clip(m, b);
        t.v2     = to_clip(m, c);
        t.reject = same_plane_reject(t.v0, t.v1, t.v2);
        if (idx < draw_rej.size()) begin
            assert (t.reject == draw_rej[idx]) else begin
                other_count++;
                $display("Reference reject for triangle %0d disagrees with the table", idx);
            end
        end
        exp_q.push_back(t);
    endtask

    task automatic load_matrix(mat4_t m);
        @(negedge clk);
        i_mvp    = m;
        i_mvp_dv = 1'b1;
        @(negedge clk);
        i_mvp_dv = 1'b0;
        check_bit("o_ready", 1'b0, o_ready);
        @(negedge clk);
        check_bit("o_ready", 1'b1, o_ready);
    endtask

    task automatic run_draw(mat4_t m, int gap);
        int n;
        n = draw_verts.size();
        load_matrix(m);
        for (int i = 0; i < n; i++) begin
            if (i > 0) begin
                @(negedge clk);
            end
            i_vertex      = draw_verts[i];
            i_vertex_dv   = 1'b1;
            i_vertex_last = (i == n - 1);
            if (i % 3 == 2) begin
                push_expected(m, draw_verts[i-2], draw_verts[i-1], draw_verts[i], i / 3);
            end
            if (i < n - 1) begin
                repeat (gap) begin
                    @(negedge clk);
                    i_vertex_dv = 1'b0;
                end
            end
        end
        // Finished pulse lands 6 cycles after the last vertex
        for (int k = 1; k <= 7; k++) begin
            @(negedge clk);
            i_vertex_dv   = 1'b0;
            i_vertex_last = 1'b0;
            check_bit("o_finished", k == 6, o_finished);
            check_bit("o_ready", k < 6, o_ready);
        end
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0 && cycles < 400) begin
            @(negedge clk);
            check_bit("o_ready", 1'b0, o_ready);
            cycles++;
        end
        assert (exp_q.size() == 0) else begin
            other_count++;
            $display("Timeout: %0d triangles never came out of the pipeline", exp_q.size());
        end
    endtask

    task automatic select_draw(int d);
        draw_verts.delete();
        draw_rej.delete();
        foreach (tbl[i]) begin
            if (tbl[i].draw == d) begin
                draw_verts.push_back(tbl[i].a);
                draw_verts.push_back(tbl[i].b);
                draw_verts.push_back(tbl[i].c);
                draw_rej.push_back(tbl[i].rej);
            end
        end
    endtask

    always @(negedge clk) begin : tri_monitor
        tri_t exp_tri;
        if (rstn && o_tri_dv) begin
            assert (exp_q.size() != 0) else begin
                other_count++;
                $display("Unexpected triangle at %0t with none left to expect", $time);
            end
            if (exp_q.size() != 0) begin
                exp_tri = exp_q.pop_front();
                check_vec("o_tri.v0", exp_tri.v0, o_tri.v0);
                check_vec("o_tri.v1", exp_tri.v1, o_tri.v1);
                check_vec("o_tri.v2", exp_tri.v2, o_tri.v2);
                check_bit("o_tri.reject", exp_tri.reject, o_tri.reject);
            end
        end
    end

    initial begin
        void'($urandom(32'h866f4b9c));
        clk            = 1'b0;
        rstn           = 1'b0;
        i_mvp          = '0;
        i_mvp_dv       = 1'b0;
        i_vertex       = '0;
        i_vertex_dv    = 1'b0;
        i_vertex_last  = 1'b0;
        mismatch_count = 0;
        other_count    = 0;

        mats[0] = diag(1.0, 1.0, 1.0);
        mats[1] = diag(2.0, 0.5, 1.0);
        // Mixed rotation-like terms and translation
        mats[2].r0 = v4(1.0, 0.25, 0.0, 0.5);
        mats[2].r1 = v4(0.0, 1.0, -0.5, 0.0);
        mats[2].r2 = v4(0.125, 0.0, 1.0, -0.25);
        mats[2].r3 = v4(0.0, 0.0, 0.0, 1.0);

        // Identity draw with one triangle beyond each plane and then straddling ones
        add_row(0, v3(1.5, 0.0, 0.0), v3(1.75, 0.5, 0.0), v3(1.25, -0.5, 0.5), 1'b1);
        add_row(0, v3(-1.5, 0.0, 0.0), v3(-2.0, 0.5, 0.0), v3(-1.25, -0.5, 0.0), 1'b1);
        add_row(0, v3(0.0, 1.5, 0.0), v3(0.5, 1.25, 0.0), v3(-0.5, 1.75, 0.0), 1'b1);
        add_row(0, v3(0.0, -1.5, 0.0), v3(0.5, -1.25, 0.0), v3(-0.5, -2.0, 0.0), 1'b1);
        add_row(0, v3(0.0, 0.0, 1.5), v3(0.5, 0.0, 1.25), v3(0.0, 0.5, 1.75), 1'b1);
        add_row(0, v3(0.0, 0.0, -1.5), v3(0.5, 0.0, -1.25), v3(0.0, 0.5, -1.75), 1'b1);
        add_row(0, v3(1.5, 0.0, 0.0), v3(-1.5, 0.0, 0.0), v3(0.0, 1.5, 0.0), 1'b0);
        add_row(0, v3(1.5, 1.5, 0.0), v3(1.5, 0.0, 0.0), v3(0.0, 1.5, 0.0), 1'b0);
        add_row(0, v3(0.25, 0.25, 0.25), v3(-0.5, 0.5, 0.0), v3(0.0, -0.5, 0.5), 1'b0);
        // Scaling draw where x is doubled and y halved before the plane test
        add_row(1, v3(0.75, 0.0, 0.0), v3(0.6, 0.2, 0.0), v3(0.9, -0.3, 0.0), 1'b1);
        add_row(1, v3(0.0, 1.5, 0.0), v3(0.25, 1.75, 0.0), v3(-0.25, 1.25, 0.0), 1'b0);
        add_row(1, v3(0.0, -3.0, 0.0), v3(0.1, -2.5, 0.0), v3(0.0, -2.2, 0.0), 1'b1);

        repeat (10) @(negedge clk);
        rstn = 1'b1;
        @(negedge clk);
        check_bit("o_ready", 1'b0, o_ready);
        check_bit("o_finished", 1'b0, o_finished);
        check_bit("o_tri_dv", 1'b0, o_tri_dv);
        check_bit("o_overflow", 1'b0, o_overflow);

        for (int d = 0; d < 2; d++) begin
            select_draw(d);
            run_draw(mats[d], 2);
            wait_drain();
        end

        // Twelve random vertices back to back
        draw_verts.delete();
        draw_rej.delete();
        for (int i = 0; i < 12; i++) begin
            draw_verts.push_back({fixed_t'(int'($urandom & 32'h3fff) - 8192),
                                  fixed_t'(int'($urandom & 32'h3fff) - 8192),
                                  fixed_t'(int'($urandom & 32'h3fff) - 8192)});
        end
        run_draw(mats[2], 0);
        wait_drain();
        check_bit("o_overflow", 1'b0, o_overflow);

        $display("Error counts: %0d mismatches, %0d other failures",
                 mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+hdl
hdl/geom_pkg.sv
hdl/mat_vec_mul.sv
hdl/vertex_shader.sv
hdl/vertex_fifo.sv
hdl/primitive_assembler.sv
hdl/geom_pipeline.sv
test/geom_pipeline_tb.sv

// ==== Bender.yml ====
package:
  name: geom_pipeline

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/geom_pkg.sv
      - hdl/mat_vec_mul.sv
      - hdl/vertex_shader.sv
      - hdl/vertex_fifo.sv
      - hdl/primitive_assembler.sv
      - hdl/geom_pipeline.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - test/geom_pipeline_tb.sv
